// File: source/periph_map_pkg.sv
package periph_map_pkg;

	// bus widths
	localparam int unsigned ADDR_WIDTH = 27;
	localparam int unsigned DATA_WIDTH = 32;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;

	// word addresses of the peripheral window
	localparam addr_t COMM_REGISTER0    = 27'h7FF_F000;
	localparam addr_t COMM_CONTROL      = 27'h7FF_F001;
	localparam addr_t PHASE_REG         = 27'h7FF_F002;
	localparam addr_t CPC_METRIC_SWITCH = 27'h7FF_F003;
	localparam addr_t STATS_BASE        = 27'h7FF_F004;

	// cache status read-through
	localparam addr_t COMM_CACHE0       = 27'h7FF_F005;
	localparam addr_t COMM_CACHE1       = 27'h7FF_F006;
	localparam addr_t COMM_CACHE2       = 27'h7FF_F007;

	// both read ports show this until the first read
	localparam data_t RESET_READ_VALUE  = 32'hDEAD_BEAF;

	// event counters behind STATS_BASE
	localparam int unsigned NUM_COUNTERS = 6;

endpackage

// File: source/periph_types_pkg.sv
package periph_types_pkg;

	import periph_map_pkg::*;

	// one select bit per mapped address
	localparam int unsigned NUM_SELECTS = 8;
	localparam int unsigned SEL_MAILBOX = 0;
	localparam int unsigned SEL_CONTROL = 1;
	localparam int unsigned SEL_PHASE   = 2;
	localparam int unsigned SEL_METRIC  = 3;
	localparam int unsigned SEL_STATS   = 4;
	localparam int unsigned SEL_CACHE0  = 5;
	localparam int unsigned SEL_CACHE1  = 6;
	localparam int unsigned SEL_CACHE2  = 7;

	typedef logic [NUM_SELECTS-1:0] reg_sel_t;

	// one captured request, decoded
	typedef struct packed {
		logic     valid;
		logic     rw;
		reg_sel_t sel;
		data_t    data;
	} bus_req_t;

	typedef logic [31:0] count_t;
	typedef count_t [NUM_COUNTERS-1:0] count_bank_t;
	typedef logic [NUM_COUNTERS-1:0] event_vec_t;

	typedef logic [1:0]  metric_sel_t;
	typedef logic [7:0]  core_ctrl_t;
	typedef logic [23:0] cs_ctrl_t;

	// self-clearing command bits
	localparam int unsigned CS_TABLE_WRITE_BIT    = 22;
	localparam int unsigned CS_SAMPLER_CLEAR_BIT  = 23;
	localparam int unsigned PHASE_IRQ_BIT         = 31;

endpackage

// File: source/bus_capture.sv
module bus_capture
	import periph_map_pkg::*;
	import periph_types_pkg::*;
(
	input  logic     clock_i,
	input  logic     reset_i,
	input  logic     core_req_i,
	input  logic     core_rw_i,
	input  addr_t    core_addr_i,
	input  data_t    core_data_i,
	input  logic     cs_req_i,
	input  logic     cs_rw_i,
	input  addr_t    cs_addr_i,
	input  data_t    cs_data_i,
	output bus_req_t core_req_o,
	output bus_req_t cs_req_o
);

	logic     core_valid_q, cs_valid_q;
	logic     core_rw_q, cs_rw_q;
	reg_sel_t core_sel_q, cs_sel_q;
	data_t    core_data_q, cs_data_q;

	// unmapped address gives no select at all
	function automatic reg_sel_t decode_addr(input addr_t addr);
		reg_sel_t sel;
		sel = '0;
		case (addr)
			COMM_REGISTER0:    sel[SEL_MAILBOX] = 1'b1;
			COMM_CONTROL:      sel[SEL_CONTROL] = 1'b1;
			PHASE_REG:         sel[SEL_PHASE]   = 1'b1;
			CPC_METRIC_SWITCH: sel[SEL_METRIC]  = 1'b1;
			STATS_BASE:        sel[SEL_STATS]   = 1'b1;
			COMM_CACHE0:       sel[SEL_CACHE0]  = 1'b1;
			COMM_CACHE1:       sel[SEL_CACHE1]  = 1'b1;
			COMM_CACHE2:       sel[SEL_CACHE2]  = 1'b1;
			default:           sel = '0;
		endcase
		return sel;
	endfunction

	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			core_valid_q <= 1'b0;
			cs_valid_q   <= 1'b0;
		end else begin
			core_valid_q <= core_req_i;
			cs_valid_q   <= cs_req_i;
		end
	end

	// request payload, meaningful only with valid
	always_ff @(posedge clock_i) begin
		core_rw_q   <= core_rw_i;
		core_sel_q  <= decode_addr(core_addr_i);
		core_data_q <= core_data_i;
		cs_rw_q     <= cs_rw_i;
		cs_sel_q    <= decode_addr(cs_addr_i);
		cs_data_q   <= cs_data_i;
	end

	assign core_req_o = '{valid: core_valid_q, rw: core_rw_q, sel: core_sel_q, data: core_data_q};
	assign cs_req_o   = '{valid: cs_valid_q, rw: cs_rw_q, sel: cs_sel_q, data: cs_data_q};

endmodule

// File: source/comm_registers.sv
module comm_registers
	import periph_map_pkg::*;
	import periph_types_pkg::*;
(
	input  logic        clock_i,
	input  logic        reset_i,
	input  bus_req_t    core_req_i,
	input  bus_req_t    cs_req_i,
	input  count_bank_t counts_i,
	input  data_t       cache0_i,
	input  data_t       cache1_i,
	input  data_t       cache2_i,
	output data_t       core_data_o,
	output data_t       cs_data_o,
	output data_t       comm_o,
	output data_t       phase_o,
	output metric_sel_t metric_sel_o,
	output cs_ctrl_t    cs_ctrl_o
);

	data_t       mailbox_q;
	data_t       snapshot_q;
	core_ctrl_t  core_ctrl_q;
	cs_ctrl_t    cs_ctrl_q;
	data_t       phase_q;
	metric_sel_t metric_sel_q;

	logic        core_wr, core_rd;
	logic        cs_wr, cs_rd;
	logic [2:0]  stats_idx;

	assign core_wr   = core_req_i.valid & core_req_i.rw;
	assign core_rd   = core_req_i.valid & ~core_req_i.rw;
	assign cs_wr     = cs_req_i.valid & cs_req_i.rw;
	assign cs_rd     = cs_req_i.valid & ~cs_req_i.rw;
	assign stats_idx = cs_req_i.data[2:0];

	// control fields, phase and metric select
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			core_ctrl_q  <= '0;
			cs_ctrl_q    <= '0;
			phase_q      <= '0;
			metric_sel_q <= '0;
		end else begin
			// command and interrupt bits last one cycle unless rewritten
			cs_ctrl_q[CS_SAMPLER_CLEAR_BIT] <= 1'b0;
			cs_ctrl_q[CS_TABLE_WRITE_BIT]   <= 1'b0;
			phase_q[PHASE_IRQ_BIT]          <= 1'b0;

			if (core_wr && core_req_i.sel[SEL_CONTROL]) begin
				core_ctrl_q <= core_req_i.data[7:0];
			end
			if (core_wr && core_req_i.sel[SEL_PHASE]) begin
				phase_q <= {1'b1, core_req_i.data[30:0]};
			end
			if (cs_wr && cs_req_i.sel[SEL_CONTROL]) begin
				cs_ctrl_q <= cs_req_i.data[23:0];
			end
			if (cs_wr && cs_req_i.sel[SEL_METRIC]) begin
				metric_sel_q <= cs_req_i.data[1:0];
			end
		end
	end

	// mailbox and counter snapshot
	always_ff @(posedge clock_i) begin
		if (cs_wr && cs_req_i.sel[SEL_MAILBOX]) begin
			mailbox_q <= cs_req_i.data;
		end
		// core wins a same-cycle collision
		if (core_wr && core_req_i.sel[SEL_MAILBOX]) begin
			mailbox_q <= core_req_i.data;
		end
		if (cs_wr && cs_req_i.sel[SEL_STATS]) begin
			if (stats_idx < 3'(NUM_COUNTERS)) begin
				snapshot_q <= counts_i[stats_idx];
			end else begin
				snapshot_q <= '0;
			end
		end
	end

	// read ports hold their last value between reads
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			core_data_o <= RESET_READ_VALUE;
			cs_data_o   <= RESET_READ_VALUE;
		end else begin
			if (core_rd && core_req_i.sel[SEL_MAILBOX]) begin
				core_data_o <= mailbox_q;
			end
			if (cs_rd) begin
				case (1'b1)
					cs_req_i.sel[SEL_MAILBOX]: cs_data_o <= mailbox_q;
					cs_req_i.sel[SEL_STATS]:   cs_data_o <= snapshot_q;
					cs_req_i.sel[SEL_CACHE0]:  cs_data_o <= cache0_i;
					cs_req_i.sel[SEL_CACHE1]:  cs_data_o <= cache1_i;
					cs_req_i.sel[SEL_CACHE2]:  cs_data_o <= cache2_i;
					default:                   cs_data_o <= '0;
				endcase
			end
		end
	end

	// core byte sits above the control system field
	assign comm_o       = {core_ctrl_q, cs_ctrl_q};
	assign phase_o      = phase_q;
	assign metric_sel_o = metric_sel_q;
	assign cs_ctrl_o    = cs_ctrl_q;

endmodule

// File: source/cycle_counters.sv
module cycle_counters
	import periph_map_pkg::*;
	import periph_types_pkg::*;
(
	input  logic        clock_i,
	input  logic        reset_i,
	input  logic        clear_i,
	input  event_vec_t  events_i,
	output count_bank_t counts_o
);

	count_bank_t counts_q;
	count_bank_t counts_next;

	// each counter wraps and steps on its own event bit
	always_comb begin
		for (int i = 0; i < NUM_COUNTERS; i++) begin
			if (events_i[i]) begin
				counts_next[i] = counts_q[i] + count_t'(1);
			end else begin
				counts_next[i] = counts_q[i];
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			counts_q <= '0;
		end else if (clear_i) begin
			// sampler clear beats any event in the same cycle
			counts_q <= '0;
		end else begin
			counts_q <= counts_next;
		end
	end

	assign counts_o = counts_q;

endmodule

// File: source/peripheral_top.sv
module peripheral_top
	import periph_map_pkg::*;
	import periph_types_pkg::*;
(
	input  logic        clock_i,
	input  logic        reset_i,
	input  logic        core_req_i,
	input  logic        core_rw_i,
	input  addr_t       core_addr_i,
	input  data_t       core_data_i,
	input  logic        cs_req_i,
	input  logic        cs_rw_i,
	input  addr_t       cs_addr_i,
	input  data_t       cs_data_i,
	input  event_vec_t  events_i,
	input  data_t       cache0_i,
	input  data_t       cache1_i,
	input  data_t       cache2_i,
	output data_t       core_data_o,
	output data_t       cs_data_o,
	output data_t       comm_o,
	output data_t       phase_o,
	output metric_sel_t metric_sel_o
);

	bus_req_t    core_req;
	bus_req_t    cs_req;
	cs_ctrl_t    cs_ctrl;
	count_bank_t counts;

	// stage 1, capture and decode
	bus_capture bus_capture_inst (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.core_req_i  (core_req_i),
		.core_rw_i   (core_rw_i),
		.core_addr_i (core_addr_i),
		.core_data_i (core_data_i),
		.cs_req_i    (cs_req_i),
		.cs_rw_i     (cs_rw_i),
		.cs_addr_i   (cs_addr_i),
		.cs_data_i   (cs_data_i),
		.core_req_o  (core_req),
		.cs_req_o    (cs_req)
	);

	// stage 2, register file
	comm_registers comm_registers_inst (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.core_req_i   (core_req),
		.cs_req_i     (cs_req),
		.counts_i     (counts),
		.cache0_i     (cache0_i),
		.cache1_i     (cache1_i),
		.cache2_i     (cache2_i),
		.core_data_o  (core_data_o),
		.cs_data_o    (cs_data_o),
		.comm_o       (comm_o),
		.phase_o      (phase_o),
		.metric_sel_o (metric_sel_o),
		.cs_ctrl_o    (cs_ctrl)
	);

	// counter bank, cleared by the sampler-clear command bit
	cycle_counters cycle_counters_inst (
		.clock_i  (clock_i),
		.reset_i  (reset_i),
		.clear_i  (cs_ctrl[CS_SAMPLER_CLEAR_BIT]),
		.events_i (events_i),
		.counts_o (counts)
	);

endmodule

// File: sim/clock_gen.sv
module clock_gen (
	output logic clock_o,
	output logic reset_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// 4 ns period, reset low across the first two rising edges
	initial begin
		clock_o = 1'b0;
		reset_o = 1'b0;
		repeat (4) #2 clock_o = ~clock_o;
		// released on a falling edge, clear of the sampling edge
		reset_o = 1'b1;
		forever #2 clock_o = ~clock_o;
	end

endmodule

// File: sim/peripheral_tests.svh
`ifndef PERIPHERAL_TESTS_SVH
`define PERIPHERAL_TESTS_SVH

// just past the peripheral window
localparam addr_t UNMAPPED_ADDR = 27'h7FF_F008;

task automatic core_access(input logic rw, input addr_t addr, input data_t data);
	@(posedge clock_i);
	core_req_i  <= 1'b1;
	core_rw_i   <= rw;
	core_addr_i <= addr;
	core_data_i <= data;
	@(posedge clock_i);
	core_req_i  <= 1'b0;
endtask

task automatic cs_access(input logic rw, input addr_t addr, input data_t data);
	@(posedge clock_i);
	cs_req_i  <= 1'b1;
	cs_rw_i   <= rw;
	cs_addr_i <= addr;
	cs_data_i <= data;
	@(posedge clock_i);
	cs_req_i  <= 1'b0;
endtask

// request was captured at the last edge, result follows the next one
task automatic wait_result();
	@(posedge clock_i);
	@(negedge clock_i);
endtask

task automatic reset_values();
	check_data("reset core read", RESET_READ_VALUE, core_data_o);
	check_data("reset cs read", RESET_READ_VALUE, cs_data_o);
	check_ctrl("reset comm", '0, comm_o);
	check_ctrl("reset phase", '0, phase_o);
	check_metric("reset metric", '0, metric_sel_o);
endtask

task automatic read_mailbox(input string name, input data_t expected);
	core_access(1'b0, COMM_REGISTER0, '0);
	wait_result();
	check_data({name, " core read"}, expected, core_data_o);
	cs_access(1'b0, COMM_REGISTER0, '0);
	wait_result();
	check_data({name, " cs read"}, expected, cs_data_o);
endtask

task automatic mailbox_sharing();
	data_t word;
	data_t held;
	word = $random(seed);
	core_access(1'b1, COMM_REGISTER0, word);
	wait_result();
	read_mailbox("mailbox core write", word);
	word = $random(seed);
	cs_access(1'b1, COMM_REGISTER0, word);
	wait_result();
	read_mailbox("mailbox cs write", word);
	held = core_data_o;
	// mailbox moves on while the core port keeps its last read
	cs_access(1'b1, COMM_REGISTER0, ~held);
	wait_result();
	core_access(1'b0, UNMAPPED_ADDR, '0);
	wait_result();
	check_data("core unmapped read", held, core_data_o);
	cs_access(1'b0, UNMAPPED_ADDR, '0);
	wait_result();
	check_data("cs unmapped read", '0, cs_data_o);
endtask

task automatic control_fields();
	core_ctrl_t core_byte;
	cs_ctrl_t   cs_field;
	core_byte = 8'hA5;
	// both command bits set along with ordinary bits
	cs_field  = 24'hC1_2345;
	core_access(1'b1, COMM_CONTROL, {24'hFF_FFFF, core_byte});
	wait_result();
	check_ctrl("control core byte", {core_byte, 24'h00_0000}, comm_o);
	cs_access(1'b1, COMM_CONTROL, {8'hFF, cs_field});
	wait_result();
	check_ctrl("control cs field", {core_byte, cs_field}, comm_o);
	@(negedge clock_i);
	check_ctrl("control command clear", {core_byte, cs_field & 24'h3F_FFFF}, comm_o);
endtask

task automatic phase_and_metric();
	data_t word;
	word = $random(seed);
	core_access(1'b1, PHASE_REG, word);
	wait_result();
	check_ctrl("phase irq set", {1'b1, word[30:0]}, phase_o);
	@(negedge clock_i);
	check_ctrl("phase irq clear", {1'b0, word[30:0]}, phase_o);
	// every write changes the select
	for (int m = 3; m >= 0; m--) begin
		word = $random(seed);
		word[1:0] = 2'(m);
		cs_access(1'b1, CPC_METRIC_SWITCH, word);
		wait_result();
		check_metric("metric switch", metric_sel_t'(m), metric_sel_o);
	end
endtask

task automatic counter_snapshots();
	event_vec_t ev;
	data_t      expected;
	// counters run up before the sampler clear
	@(posedge clock_i);
	events_i <= '1;
	// sampler clear is bit 23 of the cs field
	cs_access(1'b1, COMM_CONTROL, 32'h0080_0000);
	wait_result();
	// clear lands on the first edge here, event i then stays high 5+i cycles
	for (int c = 0; c < 12; c++) begin
		@(posedge clock_i);
		for (int i = 0; i < NUM_COUNTERS; i++) begin
			ev[i] = (c < 5 + i);
		end
		events_i <= ev;
	end
	for (int idx = 0; idx < 8; idx++) begin
		cs_access(1'b1, STATS_BASE, data_t'(idx));
		cs_access(1'b0, STATS_BASE, '0);
		wait_result();
		expected = (idx < NUM_COUNTERS) ? data_t'(5 + idx) : '0;
		check_data($sformatf("stats index %0d", idx), expected, cs_data_o);
	end
endtask

task automatic cache_readback();
	data_t words[3];
	for (int i = 0; i < 3; i++) begin
		words[i] = $random(seed);
	end
	@(posedge clock_i);
	cache0_i <= words[0];
	cache1_i <= words[1];
	cache2_i <= words[2];
	cs_access(1'b0, COMM_CACHE0, '0);
	wait_result();
	check_data("cache0 read", words[0], cs_data_o);
	cs_access(1'b0, COMM_CACHE1, '0);
	wait_result();
	check_data("cache1 read", words[1], cs_data_o);
	cs_access(1'b0, COMM_CACHE2, '0);
	wait_result();
	check_data("cache2 read", words[2], cs_data_o);
endtask

`endif

// File: sim/peripheral_tb.sv
module peripheral_tb
	import periph_map_pkg::*;
	import periph_types_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// tests take under 200 cycles
	localparam int TIMEOUT_CYCLES = 2000;

	logic        clock_i, reset_i;
	logic        core_req_i, core_rw_i, cs_req_i, cs_rw_i;
	addr_t       core_addr_i, cs_addr_i;
	data_t       core_data_i, cs_data_i;
	data_t       cache0_i, cache1_i, cache2_i;
	event_vec_t  events_i;
	data_t       core_data_o, cs_data_o, comm_o, phase_o;
	metric_sel_t metric_sel_o;
	integer      seed;
	int          error_count;
	int          cycle_count;

	clock_gen clock_gen_inst (
		.clock_o (clock_i),
		.reset_o (reset_i)
	);

	peripheral_top peripheral_top_inst (.*);

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_metric(input string name, input metric_sel_t expected,
			input metric_sel_t actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	// comm_o and phase_o words
	task automatic check_ctrl(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	`include "peripheral_tests.svh"

	initial begin
		seed = 67617;
		error_count = 0;
		{core_req_i, core_rw_i, cs_req_i, cs_rw_i} = '0;
		{core_addr_i, cs_addr_i} = '0;
		{core_data_i, cs_data_i} = '0;
		{cache0_i, cache1_i, cache2_i} = '0;
		events_i = '0;
		wait (reset_i === 1'b1);
		@(negedge clock_i);
		reset_values();
		mailbox_sharing();
		control_fields();
		phase_and_metric();
		counter_snapshots();
		cache_readback();
		$display("checks finished with %0d errors", error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock_i);
			cycle_count++;
		end
		$display("Error: simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+sim
source/periph_map_pkg.sv
source/periph_types_pkg.sv
source/bus_capture.sv
source/comm_registers.sv
source/cycle_counters.sv
source/peripheral_top.sv
sim/clock_gen.sv
sim/peripheral_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module peripheral_tb -o peripheral_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/peripheral_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
